/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rv_core
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
RUNFLAGS  ?= +verilator+error+limit+1000
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/rv_core_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_properties (
    input logic          clk,
    input logic          rst,
    input logic          redirect,
    input logic          stall,
    input rv_pkg::word_t hold_pc,
    input logic          id_ex_live
);
    int fail_count = 0;

    // Pipeline starts empty once reset has been seen
    assert property (@(posedge clk) rst |=> (!redirect && !stall && !id_ex_live))
        else begin
            fail_count++;
            $error("redirect, stall or decode/execute flags active right after reset");
        end

    // Taken branch or JAL kills the instruction behind it
    assert property (@(posedge clk) disable iff (rst) redirect |=> !id_ex_live)
        else begin
            fail_count++;
            $error("decode/execute register not a bubble after redirect");
        end

    assert property (@(posedge clk) disable iff (rst) (stall && !redirect) |=> $stable(hold_pc))
        else begin
            fail_count++;
            $error("fetch PC moved during a load-use stall");
        end

endmodule

`default_nettype wire

/* dv/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module tb_rv_core;
    import rv_pkg::*;

    localparam int PROG_LEN       = 14;
    localparam int RESET_CYCLES   = 8;
    localparam int DRAIN_CYCLES   = 12;
    // Load and reset take about 22 cycles, the program about 30 more
    localparam int TIMEOUT_CYCLES = 200;

    localparam logic [11:0] IMM_X1   = 12'd5;
    localparam logic [11:0] IMM_X2   = 12'd7;
    localparam logic [11:0] IMM_X11  = 12'd9;
    localparam logic [19:0] LUI_IMM  = 20'h12345;
    localparam logic [31:0] JAL_PC   = 32'd40;

    logic       clk;
    logic       rst;
    logic       imem_we;
    imem_addr_t imem_addr;
    word_t      imem_wdata;
    logic       retire_valid;
    reg_addr_t  retire_rd;
    word_t      retire_data;

    word_t      prog [16];
    word_t      model_regs [32];
    reg_addr_t  exp_rd [16];
    word_t      exp_data [16];
    logic [3:0] n_exp = '0;
    logic [3:0] ret_idx = '0;
    reg_addr_t  want_rd;
    word_t      want_data;
    int         cycle = 0;
    int         since_rst = 0;
    int         mismatches = 0;
    int         other_errors = 0;
    int         prop_errors;

    rv_core_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    bind rv_decode rv_core_properties decode_props_i (
        .clk        (clk),
        .rst        (rst),
        .redirect   (redirect),
        .stall      (stall),
        .hold_pc    (if_pc),
        .id_ex_live (id_ex.reg_we || id_ex.mem_read || id_ex.mem_write ||
                     id_ex.is_branch || id_ex.is_jal)
    );

    function automatic word_t r_type(input logic [6:0] funct7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] funct3,
                                     input reg_addr_t rd);
        return {funct7, rs2, rs1, funct3, rd, `RV_OP_REG};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] funct3, input reg_addr_t rd,
                                     input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] funct3);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, `RV_OP_LUI};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    task automatic build_program();
        prog[0]  = i_type(IMM_X1, 5'd0, 3'b000, 5'd1, `RV_OP_IMM);
        prog[1]  = i_type(IMM_X2, 5'd0, 3'b000, 5'd2, `RV_OP_IMM);
        prog[2]  = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
        prog[3]  = r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4);
        prog[4]  = s_type(12'd0, 5'd3, 5'd0);
        prog[5]  = i_type(12'd0, 5'd0, 3'b010, 5'd5, `RV_OP_LOAD);
        prog[6]  = r_type(7'h00, 5'd5, 5'd5, 3'b000, 5'd6);
        // BEQ x1,x1 jumps over the ADDI x7
        prog[7]  = b_type(13'd8, 5'd1, 5'd1, 3'b000);
        prog[8]  = i_type(12'd1, 5'd0, 3'b000, 5'd7, `RV_OP_IMM);
        prog[9]  = u_type(LUI_IMM, 5'd8);
        prog[10] = j_type(21'd8, 5'd9);
        prog[11] = i_type(12'd3, 5'd0, 3'b000, 5'd10, `RV_OP_IMM);
        prog[12] = i_type(IMM_X11, 5'd0, 3'b000, 5'd11, `RV_OP_IMM);
        prog[13] = j_type(21'd0, 5'd0);
    endtask

    task automatic expect_write(input reg_addr_t rd, input word_t value);
        if (rd != 5'd0) begin
            model_regs[rd] = value;
            exp_rd[n_exp]  = rd;
            exp_data[n_exp] = value;
            n_exp = n_exp + 4'd1;
        end
    endtask

    task automatic build_expected();
        word_t stored;
        model_regs[0] = '0;
        expect_write(5'd1, model_regs[0] + {20'd0, IMM_X1});
        expect_write(5'd2, model_regs[0] + {20'd0, IMM_X2});
        expect_write(5'd3, model_regs[1] + model_regs[2]);
        expect_write(5'd4, model_regs[3] - model_regs[1]);
        stored = model_regs[3];
        expect_write(5'd5, stored);
        expect_write(5'd6, model_regs[5] + model_regs[5]);
        if (model_regs[1] != model_regs[1]) begin
            expect_write(5'd7, model_regs[0] + 32'd1);
        end
        expect_write(5'd8, {LUI_IMM, 12'h000});
        // Link address, ADDI x10 after it is skipped
        expect_write(5'd9, JAL_PC + 32'd4);
        expect_write(5'd11, model_regs[0] + {20'd0, IMM_X11});
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (rst) begin
            since_rst <= 0;
        end else begin
            since_rst <= since_rst + 1;
        end
        if (!rst && retire_valid) begin
            ret_idx <= ret_idx + 4'd1;
        end
    end

    assign want_rd   = exp_rd[ret_idx];
    assign want_data = exp_data[ret_idx];

    // First retire is four cycles after reset is released
    assert property (@(posedge clk) (cycle > 0 && since_rst < 4) |-> !retire_valid)
        else begin
            other_errors++;
            $display("Retire pulse seen before the first instruction reached writeback");
        end

    assert property (@(posedge clk) disable iff (rst) retire_valid |-> retire_rd != 5'd0)
        else begin
            other_errors++;
            $display("Retire pulse with destination register x0");
        end

    assert property (@(posedge clk) disable iff (rst) retire_valid |-> ret_idx < n_exp)
        else begin
            other_errors++;
            $display("More retire pulses than expected, skipped instruction may have run");
        end

    assert property (@(posedge clk) disable iff (rst) retire_valid |-> retire_rd == want_rd)
        else begin
            mismatches++;
            $display("Mismatch retire_rd: got %h, expected %h",
                     $sampled(retire_rd), $sampled(want_rd));
        end

    assert property (@(posedge clk) disable iff (rst) retire_valid |-> retire_data == want_data)
        else begin
            mismatches++;
            $display("Mismatch retire_data: got %h, expected %h",
                     $sampled(retire_data), $sampled(want_data));
        end

    initial begin
        rst        = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        build_program();
        build_expected();

        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clk);
            #1;
            imem_we    = 1'b1;
            imem_addr  = 6'(i);
            imem_wdata = prog[4'(i)];
        end
        @(posedge clk);
        #1;
        imem_we = 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        #1;
        rst = 1'b0;

        while (ret_idx < n_exp && cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        if (ret_idx < n_exp) begin
            other_errors++;
            $display("Timeout after %0d cycles with %0d of %0d retires seen",
                     cycle, ret_idx, n_exp);
        end else begin
            repeat (DRAIN_CYCLES) @(posedge clk);
        end

        prop_errors = dut_i.decode_i.decode_props_i.fail_count;
        $display("Errors: %0d mismatches, %0d other, %0d property failures",
                 mismatches, other_errors, prop_errors);
        if (mismatches == 0 && other_errors == 0 && prop_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               imem_we,
    input  rv_pkg::imem_addr_t imem_addr,
    input  rv_pkg::word_t      imem_wdata,
    output logic               retire_valid,
    output rv_pkg::reg_addr_t  retire_rd,
    output rv_pkg::word_t      retire_data
);
    import rv_pkg::*;

    word_t     if_pc;
    word_t     if_instr;
    logic      if_valid;
    logic      stall;
    logic      redirect;
    word_t     redirect_pc;
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    rv_fetch fetch_i (
        .clk         (clk),
        .rst         (rst),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .if_pc       (if_pc),
        .if_instr    (if_instr),
        .if_valid    (if_valid)
    );

    rv_decode decode_i (
        .clk      (clk),
        .rst      (rst),
        .if_pc    (if_pc),
        .if_instr (if_instr),
        .if_valid (if_valid),
        .redirect (redirect),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .stall    (stall),
        .id_ex    (id_ex.producer)
    );

    rv_execute execute_i (
        .clk         (clk),
        .rst         (rst),
        .id_ex       (id_ex.consumer),
        .wb_we       (wb_we),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_mem      (ex_mem.producer)
    );

    rv_memory memory_i (
        .clk     (clk),
        .rst     (rst),
        .ex_mem  (ex_mem.consumer),
        .wb_we   (wb_we),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    // Every register write retires one instruction
    assign retire_valid = wb_we;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

`default_nettype wire

/* rtl/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_decode (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::word_t     if_pc,
    input  rv_pkg::word_t     if_instr,
    input  logic              if_valid,
    input  logic              redirect,
    input  logic              wb_we,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::word_t     wb_data,
    output logic              stall,
    id_ex_if.producer         id_ex
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    word_t      imm;
    alu_op_t    alu_op;
    wb_sel_t    wb_sel;
    logic       alu_src_imm;
    logic       reg_we;
    logic       mem_read;
    logic       mem_write;
    logic       is_branch;
    logic       is_jal;
    logic       use_rs1;
    logic       use_rs2;
    logic       bubble;
    word_t      regs [2**`RV_REG_ADDR_W];

    assign opcode = if_instr[6:0];
    assign rd     = if_instr[11:7];
    assign funct3 = if_instr[14:12];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];

    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
    assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
                    if_instr[11:8], 1'b0};
    assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
                    if_instr[30:21], 1'b0};
    assign imm_u = {if_instr[31:12], 12'b0};

    always_comb begin
        imm         = imm_i;
        alu_op      = `RV_ALU_ADD;
        wb_sel      = `RV_WB_ALU;
        alu_src_imm = 1'b0;
        reg_we      = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        is_branch   = 1'b0;
        is_jal      = 1'b0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        case (opcode)
            `RV_OP_REG: begin
                reg_we  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (funct3)
                    3'b000:  alu_op = if_instr[30] ? `RV_ALU_SUB : `RV_ALU_ADD;
                    3'b010:  alu_op = `RV_ALU_SLT;
                    3'b100:  alu_op = `RV_ALU_XOR;
                    3'b110:  alu_op = `RV_ALU_OR;
                    3'b111:  alu_op = `RV_ALU_AND;
                    default: alu_op = `RV_ALU_ADD;
                endcase
            end
            `RV_OP_IMM: begin
                reg_we      = 1'b1;
                alu_src_imm = 1'b1;
                use_rs1     = 1'b1;
            end
            `RV_OP_LUI: begin
                imm         = imm_u;
                alu_op      = `RV_ALU_PASS_B;
                alu_src_imm = 1'b1;
                reg_we      = 1'b1;
            end
            `RV_OP_LOAD: begin
                alu_src_imm = 1'b1;
                reg_we      = 1'b1;
                mem_read    = 1'b1;
                wb_sel      = `RV_WB_LOAD;
                use_rs1     = 1'b1;
            end
            `RV_OP_STORE: begin
                imm         = imm_s;
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
            end
            `RV_OP_BRANCH: begin
                imm       = imm_b;
                is_branch = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
            end
            `RV_OP_JAL: begin
                imm    = imm_j;
                is_jal = 1'b1;
                reg_we = 1'b1;
                wb_sel = `RV_WB_LINK;
            end
            default: begin
                imm = imm_i;
            end
        endcase
    end

    // Register file, x0 never written
    always_ff @(posedge clk) begin
        if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Returns the value being written this cycle
    function automatic word_t rf_read(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_we && wb_rd == addr) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    // Load in execute feeding the instruction being decoded
    assign stall = if_valid && id_ex.mem_read && id_ex.rd != '0 &&
                   ((use_rs1 && id_ex.rd == rs1) || (use_rs2 && id_ex.rd == rs2));

    assign bubble = rst || redirect || stall || !if_valid;

    always_ff @(posedge clk) begin
        if (bubble) begin
            id_ex.reg_we    <= 1'b0;
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
            id_ex.is_branch <= 1'b0;
            id_ex.is_jal    <= 1'b0;
        end else begin
            id_ex.reg_we    <= reg_we;
            id_ex.mem_read  <= mem_read;
            id_ex.mem_write <= mem_write;
            id_ex.is_branch <= is_branch;
            id_ex.is_jal    <= is_jal;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.pc          <= if_pc;
        id_ex.rs1         <= rs1;
        id_ex.rs2         <= rs2;
        id_ex.rs1_data    <= rf_read(rs1);
        id_ex.rs2_data    <= rf_read(rs2);
        id_ex.imm         <= imm;
        id_ex.rd          <= rd;
        id_ex.alu_op      <= alu_op;
        id_ex.alu_src_imm <= alu_src_imm;
        id_ex.branch_ne   <= funct3[0];
        id_ex.wb_sel      <= wb_sel;
    end

endmodule

`default_nettype wire

/* rtl/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

`define RV_XLEN         32
`define RV_REG_ADDR_W   5
`define RV_IMEM_ADDR_W  6
`define RV_DMEM_ADDR_W  6
`define RV_RESET_PC     32'h0000_0000

`define RV_OP_REG       7'b0110011
`define RV_OP_IMM       7'b0010011
`define RV_OP_LUI       7'b0110111
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_JAL       7'b1101111

`define RV_ALU_ADD      3'd0
`define RV_ALU_SUB      3'd1
`define RV_ALU_AND      3'd2
`define RV_ALU_OR       3'd3
`define RV_ALU_XOR      3'd4
`define RV_ALU_SLT      3'd5
`define RV_ALU_PASS_B   3'd6

// Writeback source select
`define RV_WB_ALU       2'd0
`define RV_WB_LOAD      2'd1
`define RV_WB_LINK      2'd2

`endif

/* rtl/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_execute (
    input  logic              clk,
    input  logic              rst,
    id_ex_if.consumer         id_ex,
    input  logic              wb_we,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::word_t     wb_data,
    output logic              redirect,
    output rv_pkg::word_t     redirect_pc,
    ex_mem_if.producer        ex_mem
);
    import rv_pkg::*;

    logic  mem_fwd_ok;
    word_t mem_fwd_data;
    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t alu_result;
    logic  branch_taken;

    // Loads in memory cannot forward, decode stalls for them
    assign mem_fwd_ok   = ex_mem.reg_we && !ex_mem.mem_read && ex_mem.rd != '0;
    assign mem_fwd_data = (ex_mem.wb_sel == `RV_WB_LINK) ? ex_mem.link_addr : ex_mem.alu_result;

    always_comb begin
        if (mem_fwd_ok && ex_mem.rd == id_ex.rs1) begin
            op_a = mem_fwd_data;
        end else if (wb_we && wb_rd == id_ex.rs1) begin
            op_a = wb_data;
        end else begin
            op_a = id_ex.rs1_data;
        end

        if (mem_fwd_ok && ex_mem.rd == id_ex.rs2) begin
            op_b = mem_fwd_data;
        end else if (wb_we && wb_rd == id_ex.rs2) begin
            op_b = wb_data;
        end else begin
            op_b = id_ex.rs2_data;
        end
    end

    assign alu_b = id_ex.alu_src_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            `RV_ALU_SUB:    alu_result = op_a - alu_b;
            `RV_ALU_AND:    alu_result = op_a & alu_b;
            `RV_ALU_OR:     alu_result = op_a | alu_b;
            `RV_ALU_XOR:    alu_result = op_a ^ alu_b;
            `RV_ALU_SLT:    alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            `RV_ALU_PASS_B: alu_result = alu_b;
            default:        alu_result = op_a + alu_b;
        endcase
    end

    // BNE inverts the equality test
    assign branch_taken = id_ex.is_branch && ((op_a == op_b) ^ id_ex.branch_ne);
    assign redirect     = branch_taken || id_ex.is_jal;
    assign redirect_pc  = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.reg_we    <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end else begin
            ex_mem.reg_we    <= id_ex.reg_we;
            ex_mem.mem_read  <= id_ex.mem_read;
            ex_mem.mem_write <= id_ex.mem_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.rd         <= id_ex.rd;
        ex_mem.wb_sel     <= id_ex.wb_sel;
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= op_b;
        ex_mem.link_addr  <= id_ex.pc + 32'd4;
    end

endmodule

`default_nettype wire

/* rtl/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_fetch (
    input  logic               clk,
    input  logic               rst,
    input  logic               imem_we,
    input  rv_pkg::imem_addr_t imem_addr,
    input  rv_pkg::word_t      imem_wdata,
    input  logic               stall,
    input  logic               redirect,
    input  rv_pkg::word_t      redirect_pc,
    output rv_pkg::word_t      if_pc,
    output rv_pkg::word_t      if_instr,
    output logic               if_valid
);
    import rv_pkg::*;

    word_t      imem [2**`RV_IMEM_ADDR_W];
    word_t      pc;
    imem_addr_t pc_idx;

    assign pc_idx = pc[`RV_IMEM_ADDR_W+1:2];

    // Program load port, driven while the core sits in reset
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    // Redirect beats stall
    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= `RV_RESET_PC;
            if_valid <= 1'b0;
        end else if (redirect) begin
            pc       <= redirect_pc;
            if_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= pc + 32'd4;
            if_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_pc    <= pc;
            if_instr <= imem[pc_idx];
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_memory (
    input  logic              clk,
    input  logic              rst,
    ex_mem_if.consumer        ex_mem,
    output logic              wb_we,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::word_t     wb_data
);
    import rv_pkg::*;

    word_t                     dmem [2**`RV_DMEM_ADDR_W];
    logic [`RV_DMEM_ADDR_W-1:0] dmem_idx;
    word_t                     load_data;

    // Word addressed, low two bits ignored
    assign dmem_idx  = ex_mem.alu_result[`RV_DMEM_ADDR_W+1:2];
    assign load_data = dmem[dmem_idx];

    always_ff @(posedge clk) begin
        if (ex_mem.mem_write) begin
            dmem[dmem_idx] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= ex_mem.reg_we && ex_mem.rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd <= ex_mem.rd;
        case (ex_mem.wb_sel)
            `RV_WB_LOAD: wb_data <= load_data;
            `RV_WB_LINK: wb_data <= ex_mem.link_addr;
            default:     wb_data <= ex_mem.alu_result;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/rv_pkg.sv */
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

    // Data word, also used for addresses
    typedef logic [`RV_XLEN-1:0] word_t;

    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // Word index into the instruction memory
    typedef logic [`RV_IMEM_ADDR_W-1:0] imem_addr_t;

    typedef logic [2:0] alu_op_t;

    // ALU result, load data or link address
    typedef logic [1:0] wb_sel_t;

endpackage

`default_nettype wire

/* rtl/rv_stage_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

interface id_ex_if;
    import rv_pkg::*;

    word_t     pc;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    reg_addr_t rd;
    alu_op_t   alu_op;
    logic      alu_src_imm;
    logic      reg_we;
    logic      mem_read;
    logic      mem_write;
    logic      is_branch;
    logic      branch_ne;
    logic      is_jal;
    wb_sel_t   wb_sel;

    modport producer (
        output pc, rs1, rs2, rs1_data, rs2_data, imm, rd, alu_op, alu_src_imm,
               reg_we, mem_read, mem_write, is_branch, branch_ne, is_jal, wb_sel
    );

    modport consumer (
        input pc, rs1, rs2, rs1_data, rs2_data, imm, rd, alu_op, alu_src_imm,
              reg_we, mem_read, mem_write, is_branch, branch_ne, is_jal, wb_sel
    );
endinterface

interface ex_mem_if;
    import rv_pkg::*;

    reg_addr_t rd;
    logic      reg_we;
    logic      mem_read;
    logic      mem_write;
    wb_sel_t   wb_sel;
    word_t     alu_result;
    word_t     store_data;
    // PC plus 4 for JAL
    word_t     link_addr;

    modport producer (
        output rd, reg_we, mem_read, mem_write, wb_sel, alu_result, store_data, link_addr
    );

    modport consumer (
        input rd, reg_we, mem_read, mem_write, wb_sel, alu_result, store_data, link_addr
    );
endinterface

`default_nettype wire

/* vlog.f */
+incdir+rtl
rtl/rv_pkg.sv
rtl/rv_stage_ifs.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_memory.sv
rtl/rv_core_top.sv
dv/rv_core_properties.sv
dv/tb_rv_core.sv
